// File: bench/merge_stim.txt
// test en len0 len1 len2 start0 start1 start2 stall beats, all fields in hex
// stall is the percent chance that out_ready is low in a cycle, beats the merged total
01 1 0006 0000 0000 1000 2000 3000 00 0006
02 7 0004 0005 0003 a000 b000 c000 00 000c
03 7 0008 0006 0007 0100 0200 0300 32 0015
04 5 0005 0004 0006 4440 5550 6660 19 000b
05 2 0003 0009 0002 fff0 0010 7ff0 46 0009
06 0 0002 0002 0002 1111 2222 3333 00 0000
07 6 0001 0001 0001 8000 9000 a000 00 0002
08 7 000a 000a 000a 0000 0fff fffc 50 001e

// File: bench/merge_tb.sv
// testbench for merge_top: clock, reset, channel drivers, output monitor, checks, watchdog
`timescale 1ns/10ps
`default_nettype none
`include "merge_consts.svh"

module merge_tb
  import merge_pkg::*;
();

  localparam int CH        = `MERGE_CHANNELS;
  localparam int FIELDS    = 10;  // words per stimulus line
  localparam int MAX_TESTS = 16;

  logic                        clk;
  logic                        rst_n;
  logic                        proc_req;
  chan_mask_t                  proc_en;
  logic                        proc_ack;
  chan_mask_t                  in_valid;
  chan_mask_t                  in_ready;
  beat_t [`MERGE_CHANNELS-1:0] in_beat;
  logic                        out_valid;
  logic                        out_ready;
  tagged_beat_t                out_beat;

  logic [`MERGE_DATA_WIDTH-1:0] stim [MAX_TESTS * FIELDS];  // test lines, flattened
  beat_t  exp_q [CH][$];           // expected beats per source
  integer seed = 32'hbc01e86f;
  int     err_count    = 0;
  int     pass_count   = 0;
  int     fail_count   = 0;
  int     num_tests    = 0;
  int     watch_cycles = 0;        // watchdog budget, 0 until the file is read
  logic   run_done;                // monitor saw proc_ack

  merge_top UUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .proc_req  (proc_req),
    .proc_en   (proc_en),
    .proc_ack  (proc_ack),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_beat   (in_beat),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_beat  (out_beat)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;  // 40 ns period
  end

  // --------------------------------------------------------------------------
  // compare tasks
  // --------------------------------------------------------------------------
  task automatic check_beat(input tagged_beat_t got, input tagged_beat_t exp);
    if (got.beat.data !== exp.beat.data || got.beat.last !== exp.beat.last) begin
      $display("Error out_beat from source %0d: data %h last %h, expected data %h last %h",
               got.src, got.beat.data, got.beat.last, exp.beat.data, exp.beat.last);
      err_count++;
    end
  endtask

  task automatic check_mask(input string name, input chan_mask_t got, input chan_mask_t exp);
    if (got !== exp) begin
      $display("Error %s: got %h, expected %h", name, got, exp);
      err_count++;
    end
  endtask

  task automatic check_count(input int got, input int exp);
    if (got != exp) begin
      $display("Error out_beat count: got %h, expected %h", got, exp);
      err_count++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Error %s: got %h, expected %h", name, got, exp);
      err_count++;
    end
  endtask

  // --------------------------------------------------------------------------
  // channel driver and output monitor
  // --------------------------------------------------------------------------
  task automatic drive_channel(input int k, input int len,
                               input logic [`MERGE_DATA_WIDTH-1:0] start, input logic en);
    if (!en) begin
      in_valid[k] = (len > 0);  // beat on offer that must never be taken
      in_beat[k]  = '{data: start, last: 1'b0};
      while (!run_done) begin
        check_flag("in_ready", in_ready[k], 1'b0);
        @(negedge clk);
      end
    end else begin
      for (int i = 0; i < len; i++) begin
        repeat ({$random(seed)} % 3) @(negedge clk);  // random idle gap
        in_valid[k] = 1'b1;
        in_beat[k]  = '{data: start + `MERGE_DATA_WIDTH'(i), last: (i == len - 1)};
        while (!in_ready[k]) @(negedge clk);
        @(negedge clk);  // accepted on the edge just passed
        in_valid[k] = 1'b0;
      end
    end
    in_valid[k] = 1'b0;
  endtask

  task automatic collect_output(input chan_mask_t en, input int stall, output int beats);
    tagged_beat_t got;
    tagged_beat_t exp;
    chan_mask_t   done_mask;  // sources whose last beat went out
    beats     = 0;
    done_mask = '0;
    while (!run_done) begin
      @(negedge clk);
      out_ready = (({$random(seed)} % 100) >= stall);
      if (out_valid && out_ready) begin  // transfer on the coming edge
        got = out_beat;
        beats++;
        if (got.src >= CH || exp_q[got.src].size() == 0) begin
          $display("unexpected beat from source %0d, nothing was due from it", got.src);
          err_count++;
        end else begin
          exp.beat = exp_q[got.src].pop_front();
          exp.src  = got.src;
          check_beat(got, exp);
          if (got.beat.last) done_mask[got.src] = 1'b1;
        end
      end
      if (proc_ack) begin
        check_mask("completed sources", done_mask, en);
        run_done = 1'b1;
      end
    end
  endtask

  // one run per stimulus line
  task automatic run_test(input int t);
    int         base;
    int         nbeats;
    int         errs_before;
    chan_mask_t en;
    beat_t      b;
    base        = t * FIELDS;
    errs_before = err_count;
    en          = chan_mask_t'(stim[base + 1]);
    for (int k = 0; k < CH; k++) begin
      exp_q[k].delete();
      for (int i = 0; i < stim[base + 2 + k]; i++) begin
        b.data = stim[base + 5 + k] + `MERGE_DATA_WIDTH'(i);  // start plus beat index
        b.last = (i == stim[base + 2 + k] - 1);
        if (en[k]) exp_q[k].push_back(b);
      end
    end
    run_done = 1'b0;
    @(negedge clk);
    proc_en  = en;
    proc_req = 1'b1;
    fork
      drive_channel(0, stim[base + 2], stim[base + 5], en[0]);
      drive_channel(1, stim[base + 3], stim[base + 6], en[1]);
      drive_channel(2, stim[base + 4], stim[base + 7], en[2]);
      collect_output(en, stim[base + 8], nbeats);
    join
    proc_req = 1'b0;
    repeat (3) begin  // single pulse only
      @(negedge clk);
      check_flag("proc_ack", proc_ack, 1'b0);
    end
    check_count(nbeats, stim[base + 9]);
    if (err_count == errs_before) begin
      pass_count++;
    end else begin
      fail_count++;
    end
    $display("test %0d: enables %b, %0d beats out, %s", stim[base], en, nbeats,
             (err_count == errs_before) ? "ok" : "FAILED");
  endtask

  // --------------------------------------------------------------------------
  // main sequence
  // --------------------------------------------------------------------------
  initial begin
    int budget;
    rst_n     = 1'b0;
    proc_req  = 1'b0;
    proc_en   = '0;
    in_valid  = '0;
    in_beat   = '0;
    out_ready = 1'b0;
    run_done  = 1'b0;
    $readmemh("bench/merge_stim.txt", stim);
    budget = 20;  // reset and idle cycles
    while (num_tests < MAX_TESTS && !$isunknown(stim[num_tests * FIELDS])) begin
      budget += 60 + 20 * (stim[num_tests * FIELDS + 2] + stim[num_tests * FIELDS + 3]
                           + stim[num_tests * FIELDS + 4]);
      num_tests++;
    end
    watch_cycles = budget;
    if (num_tests == 0) begin
      $display("the stimulus file holds no tests");
      err_count++;
    end
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    repeat (3) begin  // idle after reset, nothing requested yet
      @(negedge clk);
      check_flag("out_valid", out_valid, 1'b0);
      check_flag("proc_ack", proc_ack, 1'b0);
      check_mask("in_ready", in_ready, '0);
    end
    for (int t = 0; t < num_tests; t++) begin
      run_test(t);
    end
    $display("%0d tests: %0d passed, %0d failed, %0d errors",
             num_tests, pass_count, fail_count, err_count);
    if (fail_count == 0 && err_count == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // watchdog, budget from the frame lengths in the file
  initial begin
    wait (watch_cycles > 0);
    repeat (watch_cycles) @(posedge clk);
    $display("no result after %0d cycles, the merger appears to hang", watch_cycles);
    $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: logic/frame_fifo.sv
// tagged-beat fifo: storage, wrapping pointers, occupancy, soft clear
`timescale 1ns/10ps
`default_nettype none
`include "merge_consts.svh"

module frame_fifo
  import merge_pkg::*;
(
  input  wire logic         clk,
  input  wire logic         rst_n,       // sync, active low
  input  wire logic         soft_clear,  // empties the fifo at run start
  input  wire logic         fifo_we,     // write strobe
  input  wire tagged_beat_t fifo_wdata,  // entry to store
  output logic              fifo_full,   // no free entry
  input  wire logic         fifo_re,     // read strobe
  output tagged_beat_t      fifo_rdata,  // head entry
  output logic              fifo_empty   // nothing stored
);

  localparam int DEPTH = `MERGE_FIFO_DEPTH;
  localparam int AW    = $clog2(DEPTH);

  tagged_beat_t  mem [DEPTH];  // entry storage
  logic [AW-1:0] wr_ptr;       // next free slot, wraps by width
  logic [AW-1:0] rd_ptr;       // head slot
  logic [AW:0]   count;        // entries held, 0..DEPTH
  logic          wr_ok;        // write that lands
  logic          rd_ok;        // read that pops

  assign fifo_full  = (count == (AW + 1)'(DEPTH));
  assign fifo_empty = (count == '0);
  assign wr_ok      = fifo_we & ~fifo_full;
  assign rd_ok      = fifo_re & ~fifo_empty;
  assign fifo_rdata = mem[rd_ptr];  // readable the cycle after the write

  // ---------------------------------------------------------------------------
  // pointers and occupancy
  // ---------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n || soft_clear) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_ok) wr_ptr <= wr_ptr + 1'b1;
      if (rd_ok) rd_ptr <= rd_ptr + 1'b1;
      case ({wr_ok, rd_ok})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;          // both or neither
      endcase
    end
  end

  // storage
  always_ff @(posedge clk) begin
    if (wr_ok) begin
      mem[wr_ptr] <= fifo_wdata;
    end
  end

endmodule

`default_nettype wire

// File: logic/input_channel.sv
// input channel: one-entry holding register with ready flag
`timescale 1ns/10ps
`default_nettype none

module input_channel
  import merge_pkg::*;
(
  input  wire logic  clk,
  input  wire logic  rst_n,       // sync, active low
  input  wire logic  run_start,   // empties the register
  input  wire logic  en,          // channel takes part in the run
  input  wire logic  in_valid,    // source has a beat
  output logic       in_ready,    // register can take a beat
  input  wire beat_t in_beat,     // beat from the source
  input  wire logic  take,        // arbiter took the held beat
  output logic       held_valid,  // register holds a beat
  output beat_t      held_beat    // the held beat
);

  logic accept;  // handshake on the input side

  // ready only while enabled and empty
  assign in_ready = en & ~held_valid;
  assign accept   = in_valid & in_ready;

  // ---------------------------------------------------------------------------
  // occupancy flag
  // ---------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      held_valid <= 1'b0;
    end else if (run_start) begin
      held_valid <= 1'b0;   // fresh run, nothing held
    end else if (accept) begin
      held_valid <= 1'b1;
    end else if (take) begin
      held_valid <= 1'b0;   // frees on the take edge
    end
  end

  // payload, loads only on a handshake
  always_ff @(posedge clk) begin
    if (accept) begin
      held_beat <= in_beat;
    end
  end

endmodule

`default_nettype wire

// File: logic/merge_consts.svh
// merge constants: data width, fifo depth, channel count, source id width
`ifndef MERGE_CONSTS_SVH
`define MERGE_CONSTS_SVH

// ---------------------------------------------------------------------------
// datapath sizing
// ---------------------------------------------------------------------------
`define MERGE_DATA_WIDTH 16   // bits in one data word

`define MERGE_FIFO_DEPTH 8    // fifo entries, keep a power of two

// ---------------------------------------------------------------------------
// channel sizing
// ---------------------------------------------------------------------------
`define MERGE_CHANNELS   3    // input channels taking part in the merge

// three channels still need two bits
`define MERGE_SRC_WIDTH  2    // bits of a source channel id

`endif

// File: logic/merge_pkg.sv
// merge types: beat, tagged beat and channel mask
`default_nettype none
`include "merge_consts.svh"

package merge_pkg;

  // ---------------------------------------------------------------------------
  // beat as seen on one input channel
  // ---------------------------------------------------------------------------
  typedef struct packed {
    logic [`MERGE_DATA_WIDTH-1:0] data;  // payload word
    logic                         last;  // final beat of the frame
  } beat_t;

  // beat after arbitration, carries the channel it came from
  typedef struct packed {
    beat_t                       beat;  // original beat
    logic [`MERGE_SRC_WIDTH-1:0] src;   // source channel id
  } tagged_beat_t;

  // ---------------------------------------------------------------------------
  // one bit per channel
  // enables, completion, valid/ready bundles, grants
  // ---------------------------------------------------------------------------
  typedef logic [`MERGE_CHANNELS-1:0] chan_mask_t;

endpackage

`default_nettype wire

// File: logic/merge_top.sv
// merger top level: control, input channels, arbiter, fifo, output stage
`timescale 1ns/10ps
`default_nettype none
`include "merge_consts.svh"

module merge_top
  import merge_pkg::*;
(
  input  wire logic                        clk,
  input  wire logic                        rst_n,      // sync, active low
  input  wire logic                        proc_req,   // processing request level
  input  wire chan_mask_t                  proc_en,    // channel enables
  output wire logic                        proc_ack,   // run complete strobe
  input  wire chan_mask_t                  in_valid,   // per channel valid
  output wire chan_mask_t                  in_ready,   // per channel ready
  input  wire beat_t [`MERGE_CHANNELS-1:0] in_beat,    // per channel beat
  output wire logic                        out_valid,  // merged stream valid
  input  wire logic                        out_ready,  // merged stream ready
  output wire tagged_beat_t                out_beat    // merged beat with source
);

  // ---------------------------------------------------------------------------
  // internal nets
  // ---------------------------------------------------------------------------
  wire logic                        run_start;   // soft restart pulse
  wire chan_mask_t                  chan_en;     // latched enables
  wire logic                        last_sent;
  wire logic [`MERGE_SRC_WIDTH-1:0] last_src;
  wire chan_mask_t                  held_valid;  // channel registers full
  wire beat_t [`MERGE_CHANNELS-1:0] held_beat;
  wire chan_mask_t                  take;        // arbiter takes
  wire logic                        fifo_we;
  wire tagged_beat_t                fifo_wdata;
  wire logic                        fifo_full;
  wire logic                        fifo_re;
  wire tagged_beat_t                fifo_rdata;
  wire logic                        fifo_empty;

  proc_control u_ctrl (
    .clk       (clk),
    .rst_n     (rst_n),
    .proc_req  (proc_req),
    .proc_en   (proc_en),
    .last_sent (last_sent),
    .last_src  (last_src),
    .run_start (run_start),
    .proc_ack  (proc_ack),
    .chan_en   (chan_en)
  );

  // one holding register per channel
  for (genvar k = 0; k < `MERGE_CHANNELS; k++) begin : g_chan
    input_channel u_chan (
      .clk        (clk),
      .rst_n      (rst_n),
      .run_start  (run_start),
      .en         (chan_en[k]),
      .in_valid   (in_valid[k]),
      .in_ready   (in_ready[k]),
      .in_beat    (in_beat[k]),
      .take       (take[k]),
      .held_valid (held_valid[k]),
      .held_beat  (held_beat[k])
    );
  end

  // ---------------------------------------------------------------------------
  // producer, buffer, consumer
  // ---------------------------------------------------------------------------
  rr_arbiter u_arb (
    .clk        (clk),
    .rst_n      (rst_n),
    .run_start  (run_start),
    .held_valid (held_valid),
    .held_beat  (held_beat),
    .take       (take),
    .fifo_full  (fifo_full),
    .fifo_we    (fifo_we),
    .fifo_wdata (fifo_wdata)
  );

  frame_fifo u_fifo (
    .clk        (clk),
    .rst_n      (rst_n),
    .soft_clear (run_start),  // pointers restart with each run
    .fifo_we    (fifo_we),
    .fifo_wdata (fifo_wdata),
    .fifo_full  (fifo_full),
    .fifo_re    (fifo_re),
    .fifo_rdata (fifo_rdata),
    .fifo_empty (fifo_empty)
  );

  output_stage u_out (
    .clk        (clk),
    .rst_n      (rst_n),
    .run_start  (run_start),
    .fifo_empty (fifo_empty),
    .fifo_rdata (fifo_rdata),
    .fifo_re    (fifo_re),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_beat   (out_beat),
    .last_sent  (last_sent),
    .last_src   (last_src)
  );

endmodule

`default_nettype wire

// File: logic/output_stage.sv
// output stage: output register, valid/ready handshake, last-beat report
`timescale 1ns/10ps
`default_nettype none
`include "merge_consts.svh"

module output_stage
  import merge_pkg::*;
(
  input  wire logic                   clk,
  input  wire logic                   rst_n,       // sync, active low
  input  wire logic                   run_start,   // drops any stale beat
  input  wire logic                   fifo_empty,  // nothing to pull
  input  wire tagged_beat_t           fifo_rdata,  // fifo head
  output logic                        fifo_re,     // pop the head
  output logic                        out_valid,   // register holds a beat
  input  wire logic                   out_ready,   // sink takes it
  output tagged_beat_t                out_beat,    // beat toward the sink
  output logic                        last_sent,   // final beat transferred
  output logic [`MERGE_SRC_WIDTH-1:0] last_src     // channel of that beat
);

  logic xfer;  // handshake on the output side

  assign xfer = out_valid & out_ready;

  // pull when the register is empty or emptying now
  assign fifo_re = ~fifo_empty & (~out_valid | out_ready);

  assign last_sent = xfer & out_beat.beat.last;
  assign last_src  = out_beat.src;

  // ---------------------------------------------------------------------------
  // valid flag, holds under back-pressure
  // ---------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n || run_start) begin
      out_valid <= 1'b0;
    end else if (fifo_re) begin
      out_valid <= 1'b1;  // loaded on the same edge as the pop
    end else if (xfer) begin
      out_valid <= 1'b0;
    end
  end

  // payload
  always_ff @(posedge clk) begin
    if (fifo_re) begin
      out_beat <= fifo_rdata;
    end
  end

endmodule

`default_nettype wire

// File: logic/proc_control.sv
// processing control: run start detect, enable latch, completion tracking, ack strobe
`timescale 1ns/10ps
`default_nettype none
`include "merge_consts.svh"

module proc_control
  import merge_pkg::*;
(
  input  wire logic                        clk,
  input  wire logic                        rst_n,      // sync, active low
  input  wire logic                        proc_req,   // level from the requester
  input  wire chan_mask_t                  proc_en,    // channels wanted for the run
  input  wire logic                        last_sent,  // last beat left the output
  input  wire logic [`MERGE_SRC_WIDTH-1:0] last_src,   // its source channel
  output logic                             run_start,  // first cycle of the run
  output logic                             proc_ack,   // one cycle, run complete
  output chan_mask_t                       chan_en     // latched enables
);

  logic       req_q;     // proc_req one cycle late
  logic       active;    // run in progress
  chan_mask_t done;      // channels whose last beat has gone out
  chan_mask_t set_mask;  // completion bit raised this cycle
  chan_mask_t en_now;    // enables the ack check compares against
  chan_mask_t done_now;  // completion including this cycle
  logic       all_done;  // completion covers the enables

  // ---------------------------------------------------------------------------
  // completion check
  // ---------------------------------------------------------------------------
  always_comb begin
    set_mask = last_sent ? (chan_mask_t'(1) << last_src) : '0;
    // on run_start the new mask is not latched yet, so look at proc_en
    en_now   = run_start ? proc_en : chan_en;
    done_now = run_start ? '0 : (done | set_mask);
    // an empty proc_en finishes right on the run_start edge
    all_done = (active | run_start) && ((done_now & en_now) == en_now);
  end

  // ---------------------------------------------------------------------------
  // run state
  // ---------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      req_q     <= 1'b0;
      run_start <= 1'b0;
      proc_ack  <= 1'b0;
      active    <= 1'b0;
      chan_en   <= '0;
      done      <= '0;
    end else begin
      req_q     <= proc_req;
      run_start <= proc_req & ~req_q;  // rising edge of the level request
      proc_ack  <= all_done;           // strobe lands the cycle after
      if (all_done) begin
        active  <= 1'b0;               // run over, channels close
        chan_en <= '0;
        done    <= '0;
      end else if (run_start) begin
        active  <= 1'b1;
        chan_en <= proc_en;            // latch enables for the whole run
        done    <= '0;
      end else if (active) begin
        done    <= done_now;           // accumulate finished sources
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/rr_arbiter.sv
// round-robin arbiter: grant among held beats, source tagging, fifo write
`timescale 1ns/10ps
`default_nettype none
`include "merge_consts.svh"

module rr_arbiter
  import merge_pkg::*;
(
  input  wire logic                         clk,
  input  wire logic                         rst_n,       // sync, active low
  input  wire logic                         run_start,   // pointer back to channel 0
  input  wire chan_mask_t                   held_valid,  // channels holding a beat
  input  wire beat_t [`MERGE_CHANNELS-1:0]  held_beat,   // held beats by channel
  output chan_mask_t                        take,        // one-hot, beat taken
  input  wire logic                         fifo_full,   // no room downstream
  output logic                              fifo_we,     // fifo write strobe
  output tagged_beat_t                      fifo_wdata   // beat plus source id
);

  localparam int CH = `MERGE_CHANNELS;
  localparam int SW = `MERGE_SRC_WIDTH;

  logic [SW-1:0] ptr;     // channel with first claim
  logic [SW-1:0] gnt_id;  // winning channel
  logic          found;   // some channel holds a beat

  // ---------------------------------------------------------------------------
  // grant search, starting at the pointer and wrapping
  // ---------------------------------------------------------------------------
  always_comb begin
    int idx;
    found  = 1'b0;
    gnt_id = '0;
    for (int i = 0; i < CH; i++) begin
      idx = (int'(ptr) + i) % CH;
      if (!found && held_valid[idx]) begin
        found  = 1'b1;
        gnt_id = SW'(idx);
      end
    end
  end

  // write and take share one edge
  assign fifo_we = found & ~fifo_full;           // full blocks every grant
  assign take    = fifo_we ? (chan_mask_t'(1) << gnt_id) : '0;

  // tag the winning beat with its channel
  assign fifo_wdata = '{beat: held_beat[gnt_id], src: gnt_id};

  // ---------------------------------------------------------------------------
  // pointer moves past the last winner
  // ---------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ptr <= '0;
    end else if (run_start) begin
      ptr <= '0;                                  // each run starts at 0
    end else if (fifo_we) begin
      ptr <= (gnt_id == SW'(CH - 1)) ? '0 : gnt_id + 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+logic
logic/merge_pkg.sv
logic/proc_control.sv
logic/input_channel.sv
logic/rr_arbiter.sv
logic/frame_fifo.sv
logic/output_stage.sv
logic/merge_top.sv
bench/merge_tb.sv
